// File: Makefile
# Verilator build and run of the LSU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_lsu_top \
		-f lsu_top.f -o sim_lsu
	./obj_dir/sim_lsu +verilator+error+limit+100 | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
   input  logic      clk,
   input  logic      rst_n,
   lsu_mem_if.server mem,
   output logic      idle
);
   import lsu_types_pkg::*;
   import lsu_ctrl_pkg::*;

   data_t      mem_q [mem_words];
   logic       busy;
   lat_cnt_t   cnt;
   logic       wr_q;
   mem_index_t idx_q;
   data_t      wdata_q;

   // Contents start at zero and survive reset
   initial begin
      for (int i = 0; i < mem_words; i++) begin
         mem_q[i] = '0;
      end
   end

   assign idle      = !busy;
   assign mem.grnt  = mem.req && !busy;
   assign mem.done  = busy && (cnt == '0);
   assign mem.rdata = mem_q[idx_q];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (mem.grnt) begin
         busy <= 1'b1;
         cnt  <= lat_cnt_t'(mem_latency - 1);
      end else if (mem.done) begin
         busy <= 1'b0;
      end else if (busy) begin
         cnt <= cnt - lat_cnt_t'(1);
      end
   end

   // Request latch and array write
   always_ff @(posedge clk) begin
      if (mem.grnt) begin
         wr_q    <= mem.wr;
         idx_q   <= mem.addr[mem_index_w-1:0];
         wdata_q <= mem.wdata;
      end
      if (mem.done && wr_q) begin
         mem_q[idx_q] <= wdata_q;
      end
   end

endmodule

`default_nettype wire

// File: load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flsh,
   input  logic                 mem_rd,
   input  lsu_types_pkg::addr_t addr_ls,
   input  lsu_types_pkg::tag_t  indx_ls,
   input  logic                 fwd_hit,
   input  lsu_types_pkg::data_t fwd_data,
   output lsu_types_pkg::addr_t fwd_addr,
   output logic                 full,
   output logic                 vld_ld,
   output logic                 reg_wrt_ld,
   output lsu_types_pkg::tag_t  indx_ld,
   output lsu_types_pkg::data_t data_ld,
   lsu_mem_if.requester         mem
);
   import lsu_types_pkg::*;
   import lsu_ctrl_pkg::*;

   tag_t    tag_q  [lq_depth];
   addr_t   addr_q [lq_depth];
   data_t   data_q [lq_depth];
   logic    rdy_q  [lq_depth];

   lq_ptr_t head;
   lq_ptr_t tail;
   lq_cnt_t count;
   logic    rd_open;
   logic    rd_drop;
   logic    accept;
   logic    retire;
   logic    fill;
   logic    pending;

   // The incoming load looks up the store queue directly
   assign fwd_addr = addr_ls;

   assign tail    = head + lq_ptr_t'(count);
   assign full    = (count == lq_cnt_t'(lq_depth));
   assign accept  = mem_rd && !full && !flsh;
   assign pending = (count != '0) && !rdy_q[head];

   // Results leave from the head only, so order is kept
   assign retire     = (count != '0) && rdy_q[head];
   assign vld_ld     = retire;
   assign reg_wrt_ld = retire;
   assign indx_ld    = tag_q[head];
   assign data_ld    = data_q[head];

   // Read data of a flushed load is thrown away
   assign fill = mem.done && !rd_drop;

   ////////////////////////////////////////////////////////////////////
   // Memory read for a pending head
   ////////////////////////////////////////////////////////////////////
   assign mem.req   = pending && !rd_open && !flsh;
   assign mem.wr    = 1'b0;
   assign mem.addr  = addr_q[head];
   assign mem.wdata = '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head    <= '0;
         count   <= '0;
         rd_open <= 1'b0;
         rd_drop <= 1'b0;
      end else begin
         if (mem.grnt) begin
            rd_open <= 1'b1;
         end else if (mem.done) begin
            rd_open <= 1'b0;
         end
         // Granted read outlives the flush
         if (mem.done) begin
            rd_drop <= 1'b0;
         end else if (flsh && rd_open) begin
            rd_drop <= 1'b1;
         end
         head <= head + lq_ptr_t'(retire);
         if (flsh) begin
            count <= '0;
         end else begin
            count <= count + lq_cnt_t'(accept) - lq_cnt_t'(retire);
         end
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      if (accept) begin
         tag_q[tail]  <= indx_ls;
         addr_q[tail] <= addr_ls;
         data_q[tail] <= fwd_data;
         rdy_q[tail]  <= fwd_hit;
      end
      if (fill) begin
         data_q[head] <= mem.rdata;
         rdy_q[head]  <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: load_store_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_arbiter (
   input  logic         clk,
   input  logic         rst_n,
   lsu_mem_if.server    lq_mem,
   lsu_mem_if.server    sq_mem,
   lsu_mem_if.requester ca_mem,
   input  logic         ca_idle
);
   import lsu_ctrl_pkg::*;

   arb_state_t state;
   logic       pick_st;

   // Store queue only asks with a committed head, so it goes first
   assign pick_st = sq_mem.req;

   assign ca_mem.req   = (state == idle) && ca_idle && (lq_mem.req || sq_mem.req);
   assign ca_mem.wr    = pick_st ? sq_mem.wr    : lq_mem.wr;
   assign ca_mem.addr  = pick_st ? sq_mem.addr  : lq_mem.addr;
   assign ca_mem.wdata = pick_st ? sq_mem.wdata : lq_mem.wdata;

   // Steer the answers to the current owner only
   assign lq_mem.grnt  = ca_mem.grnt && !pick_st;
   assign sq_mem.grnt  = ca_mem.grnt && pick_st;
   assign lq_mem.done  = ca_mem.done && (state == load_busy);
   assign sq_mem.done  = ca_mem.done && (state == store_busy);
   assign lq_mem.rdata = (state == load_busy)  ? ca_mem.rdata : '0;
   assign sq_mem.rdata = (state == store_busy) ? ca_mem.rdata : '0;

   ////////////////////////////////////////////////////////////////////
   // Owner FSM
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               if (ca_mem.grnt) begin
                  state <= pick_st ? store_busy : load_busy;
               end
            end
            load_busy, store_busy: begin
               if (ca_mem.done) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flsh,
   input  logic                 mem_rd,
   input  logic                 mem_wrt,
   input  logic                 cmmt_str,
   input  lsu_types_pkg::addr_t addr_ls,
   input  lsu_types_pkg::data_t data_str,
   input  lsu_types_pkg::tag_t  indx_ls,
   input  logic                 stll,
   input  logic                 vld_ld,
   input  lsu_types_pkg::tag_t  indx_ld,
   input  lsu_types_pkg::data_t data_ld,
   input  logic                 str_iss,
   input  logic                 exp_vld,
   input  lsu_types_pkg::data_t exp_data,
   output int                   errors,
   output int                   checks,
   output logic                 drained
);
   import lsu_types_pkg::*;

   data_t mem_m [mem_words];
   // Store list, oldest first, with a committed count from the front
   addr_t st_addr [$];
   data_t st_data [$];
   int    st_cmt;
   // Predicted load results in acceptance order
   tag_t  ld_tag [$];
   data_t ld_data [$];
   logic  fast_due;

   initial begin
      for (int i = 0; i < mem_words; i++) begin
         mem_m[i] = '0;
      end
      errors   = 0;
      checks   = 0;
      st_cmt   = 0;
      fast_due = 1'b0;
      drained  = 1'b1;
   end

   task automatic compare_value(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   always @(posedge clk) begin
      data_t pred;
      logic  hit;
      if (rst_n) begin
         if (fast_due && !vld_ld) begin
            errors++;
            $display("%0t ns: forwarded load at the head did not retire next cycle", $time);
         end
         fast_due = 1'b0;
         if (vld_ld) begin
            if (ld_tag.size() == 0) begin
               errors++;
               $display("%0t ns: load result with no load outstanding", $time);
            end else begin
               compare_value("indx_ld", data_t'(indx_ld), data_t'(ld_tag.pop_front()));
               compare_value("data_ld", data_ld, ld_data.pop_front());
            end
         end
         if (str_iss) begin
            if (st_cmt == 0) begin
               errors++;
               $display("%0t ns: str_iss with no committed store", $time);
            end else begin
               mem_m[mem_index_t'(st_addr[0])] = st_data[0];
               void'(st_addr.pop_front());
               void'(st_data.pop_front());
               st_cmt--;
            end
         end
         if (cmmt_str && (st_cmt < st_addr.size())) begin
            st_cmt++;
         end
         if (flsh) begin
            ld_tag.delete();
            ld_data.delete();
            while (st_addr.size() > st_cmt) begin
               void'(st_addr.pop_back());
               void'(st_data.pop_back());
            end
         end else begin
            if (mem_rd && !stll) begin
               hit  = 1'b0;
               pred = mem_m[mem_index_t'(addr_ls)];
               // Youngest matching store wins
               for (int k = 0; k < st_addr.size(); k++) begin
                  if (st_addr[k] == addr_ls) begin
                     hit  = 1'b1;
                     pred = st_data[k];
                  end
               end
               if (exp_vld) begin
                  compare_value("table data", exp_data, pred);
               end
               ld_tag.push_back(indx_ls);
               ld_data.push_back(pred);
               if (hit && (ld_tag.size() == 1)) begin
                  fast_due = 1'b1;
               end
            end
            if (mem_wrt && !stll) begin
               st_addr.push_back(addr_ls);
               st_data.push_back(data_str);
            end
         end
         drained = (ld_tag.size() == 0) && (st_cmt == 0);
      end
   end

endmodule

`default_nettype wire

// File: lsu_ctrl_pkg.sv
`default_nettype none

package lsu_ctrl_pkg;

   localparam int lq_depth    = 8;
   localparam int sq_depth    = 8;
   localparam int mem_latency = 2;

   localparam int lq_ptr_w    = $clog2(lq_depth);
   localparam int sq_ptr_w    = $clog2(sq_depth);
   localparam int lat_cnt_w   = $clog2(mem_latency + 1);

   typedef logic [lq_ptr_w-1:0]  lq_ptr_t;
   typedef logic [lq_ptr_w:0]    lq_cnt_t;
   typedef logic [sq_ptr_w-1:0]  sq_ptr_t;
   typedef logic [sq_ptr_w:0]    sq_cnt_t;
   typedef logic [lat_cnt_w-1:0] lat_cnt_t;

   // Owner of the data memory
   typedef enum logic [1:0] {idle, load_busy, store_busy} arb_state_t;

endpackage

`default_nettype wire

// File: lsu_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// One request channel towards the data memory
interface lsu_mem_if;
   import lsu_types_pkg::*;

   logic  req;
   logic  grnt;
   logic  wr;
   addr_t addr;
   data_t wdata;
   data_t rdata;
   logic  done;

   // Request side holds req until grnt, then waits for done
   modport requester (
      output req, wr, addr, wdata,
      input  grnt, rdata, done
   );

   modport server (
      input  req, wr, addr, wdata,
      output grnt, rdata, done
   );

endinterface

`default_nettype wire

// File: lsu_props.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 stll,
   input logic                 vld_ld,
   input logic                 reg_wrt_ld,
   input lsu_types_pkg::tag_t  indx_ld,
   input lsu_types_pkg::data_t data_ld,
   input logic                 str_iss
);
   int   fail_cnt = 0;
   logic rst_seen = 1'b0;

   // First reset edge has loaded the state registers
   always @(posedge clk) begin
      if (!rst_n) begin
         rst_seen <= 1'b1;
      end
   end

   quiet_in_reset: assert property (
      @(posedge clk) (!rst_n && rst_seen) |-> (!vld_ld && !str_iss))
      else begin
         fail_cnt++;
         $error("vld_ld or str_iss high during reset");
      end

   result_writes_reg: assert property (
      @(posedge clk) (rst_n && vld_ld) |-> reg_wrt_ld)
      else begin
         fail_cnt++;
         $error("vld_ld without reg_wrt_ld");
      end

   known_strobes: assert property (
      @(posedge clk) rst_n |-> !$isunknown({stll, vld_ld, reg_wrt_ld, str_iss}))
      else begin
         fail_cnt++;
         $error("unknown strobe after reset");
      end

   // Payload only matters while a result is valid
   known_result: assert property (
      @(posedge clk) (rst_n && vld_ld) |-> !$isunknown({indx_ld, data_ld}))
      else begin
         fail_cnt++;
         $error("unknown load result");
      end

endmodule

bind lsu_top lsu_props i_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .stll       (stll),
   .vld_ld     (vld_ld),
   .reg_wrt_ld (reg_wrt_ld),
   .indx_ld    (indx_ld),
   .data_ld    (data_ld),
   .str_iss    (str_iss)
);

`default_nettype wire

// File: lsu_top.f
lsu_types_pkg.sv
lsu_ctrl_pkg.sv
lsu_mem_if.sv
load_queue.sv
store_queue.sv
load_store_arbiter.sv
data_memory.sv
lsu_top.sv
lsu_props.sv
lsu_checker.sv
tb_lsu_top.sv

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flsh,
   input  logic                 mem_rd,
   input  logic                 mem_wrt,
   input  logic                 cmmt_str,
   input  lsu_types_pkg::addr_t addr_ls,
   input  lsu_types_pkg::data_t data_str,
   input  lsu_types_pkg::tag_t  indx_ls,
   output logic                 stll,
   output logic                 vld_ld,
   output logic                 reg_wrt_ld,
   output lsu_types_pkg::tag_t  indx_ld,
   output lsu_types_pkg::data_t data_ld,
   output logic                 str_iss
);
   import lsu_types_pkg::*;

   logic  lq_full;
   logic  sq_full;
   logic  ld_acc;
   logic  st_acc;
   logic  fwd_hit;
   addr_t fwd_addr;
   data_t fwd_data;
   logic  ca_idle;

   lsu_mem_if lq_mem ();
   lsu_mem_if sq_mem ();
   lsu_mem_if ca_mem ();

   assign stll = lq_full | sq_full;

   // Operations seen during a stall are held by the source
   assign ld_acc = mem_rd & ~stll;
   assign st_acc = mem_wrt & ~stll;

   ////////////////////////////////////////////////////////////////////
   // Queues
   ////////////////////////////////////////////////////////////////////
   load_queue lq (
      .clk        (clk),
      .rst_n      (rst_n),
      .flsh       (flsh),
      .mem_rd     (ld_acc),
      .addr_ls    (addr_ls),
      .indx_ls    (indx_ls),
      .fwd_hit    (fwd_hit),
      .fwd_data   (fwd_data),
      .fwd_addr   (fwd_addr),
      .full       (lq_full),
      .vld_ld     (vld_ld),
      .reg_wrt_ld (reg_wrt_ld),
      .indx_ld    (indx_ld),
      .data_ld    (data_ld),
      .mem        (lq_mem)
   );

   store_queue sq (
      .clk      (clk),
      .rst_n    (rst_n),
      .flsh     (flsh),
      .mem_wrt  (st_acc),
      .cmmt_str (cmmt_str),
      .addr_ls  (addr_ls),
      .data_str (data_str),
      .fwd_addr (fwd_addr),
      .fwd_hit  (fwd_hit),
      .fwd_data (fwd_data),
      .full     (sq_full),
      .str_iss  (str_iss),
      .mem      (sq_mem)
   );

   ////////////////////////////////////////////////////////////////////
   // Shared memory port
   ////////////////////////////////////////////////////////////////////
   load_store_arbiter lsa (
      .clk     (clk),
      .rst_n   (rst_n),
      .lq_mem  (lq_mem),
      .sq_mem  (sq_mem),
      .ca_mem  (ca_mem),
      .ca_idle (ca_idle)
   );

   data_memory mem_sys (
      .clk   (clk),
      .rst_n (rst_n),
      .mem   (ca_mem),
      .idle  (ca_idle)
   );

endmodule

`default_nettype wire

// File: lsu_types_pkg.sv
`default_nettype none

package lsu_types_pkg;

   // Datapath widths
   localparam int addr_w      = 16;
   localparam int data_w      = 16;
   localparam int tag_w       = 6;
   localparam int mem_index_w = 8;
   localparam int mem_words   = 2 ** mem_index_w;

   // Byte address of a load or store
   typedef logic [addr_w-1:0]      addr_t;

   // Load and store payload
   typedef logic [data_w-1:0]      data_t;

   // Destination register index travelling with a load
   typedef logic [tag_w-1:0]       tag_t;

   // Word index into the data memory, low address bits
   typedef logic [mem_index_w-1:0] mem_index_t;

endpackage

`default_nettype wire

// File: store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flsh,
   input  logic                 mem_wrt,
   input  logic                 cmmt_str,
   input  lsu_types_pkg::addr_t addr_ls,
   input  lsu_types_pkg::data_t data_str,
   input  lsu_types_pkg::addr_t fwd_addr,
   output logic                 fwd_hit,
   output lsu_types_pkg::data_t fwd_data,
   output logic                 full,
   output logic                 str_iss,
   lsu_mem_if.requester         mem
);
   import lsu_types_pkg::*;
   import lsu_ctrl_pkg::*;

   addr_t   addr_q [sq_depth];
   data_t   data_q [sq_depth];

   sq_ptr_t head;
   sq_ptr_t tail;
   sq_ptr_t head_next;
   sq_cnt_t count;
   sq_cnt_t cnt_next;
   // Committed entries, counted from the head
   sq_cnt_t cmt_cnt;
   sq_cnt_t cmt_next;
   logic    wr_open;
   logic    accept;
   logic    commit;
   logic    free;

   assign tail   = head + sq_ptr_t'(count);
   assign full   = (count == sq_cnt_t'(sq_depth));
   assign accept = mem_wrt && !full && !flsh;

   // A commit with nothing left to commit is dropped
   assign commit = cmmt_str && (cmt_cnt != count);
   assign free   = mem.done;

   assign head_next = head + sq_ptr_t'(free);
   assign cmt_next  = cmt_cnt + sq_cnt_t'(commit) - sq_cnt_t'(free);
   assign cnt_next  = count + sq_cnt_t'(accept) - sq_cnt_t'(free);

   assign str_iss = free;

   ////////////////////////////////////////////////////////////////////
   // Forwarding lookup
   ////////////////////////////////////////////////////////////////////
   // Walk oldest to youngest so the last match wins
   always_comb begin
      fwd_hit  = 1'b0;
      fwd_data = '0;
      for (int k = 0; k < sq_depth; k++) begin
         if ((sq_cnt_t'(k) < count) && (addr_q[head + sq_ptr_t'(k)] == fwd_addr)) begin
            fwd_hit  = 1'b1;
            fwd_data = data_q[head + sq_ptr_t'(k)];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Memory write of the committed head
   ////////////////////////////////////////////////////////////////////
   assign mem.req   = (cmt_cnt != '0) && !wr_open;
   assign mem.wr    = 1'b1;
   assign mem.addr  = addr_q[head];
   assign mem.wdata = data_q[head];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head    <= '0;
         count   <= '0;
         cmt_cnt <= '0;
         wr_open <= 1'b0;
      end else begin
         if (mem.grnt) begin
            wr_open <= 1'b1;
         end else if (mem.done) begin
            wr_open <= 1'b0;
         end
         head    <= head_next;
         cmt_cnt <= cmt_next;
         // Flush keeps only the committed run behind the head
         if (flsh) begin
            count <= cmt_next;
         end else begin
            count <= cnt_next;
         end
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q[tail] <= addr_ls;
         data_q[tail] <= data_str;
      end
   end

endmodule

`default_nettype wire

// File: tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
   import lsu_types_pkg::*;

   localparam int max_rows  = 128;
   localparam int op_idle   = 0;
   localparam int op_store  = 1;
   localparam int op_load   = 2;
   localparam int op_commit = 3;
   localparam int op_flush  = 4;
   // Load reference codes for no expectation and for zero data
   localparam int no_ref    = -2;
   localparam int zero_ref  = -1;

   logic        clk;
   logic        rst_n;
   logic        flsh;
   logic        mem_rd;
   logic        mem_wrt;
   logic        cmmt_str;
   addr_t       addr_ls;
   data_t       data_str;
   tag_t        indx_ls;
   logic        stll;
   logic        vld_ld;
   logic        reg_wrt_ld;
   tag_t        indx_ld;
   data_t       data_ld;
   logic        str_iss;
   logic        exp_vld;
   data_t       exp_data;
   int          errors;
   int          checks;
   logic        drained;

   int          op_tab   [max_rows];
   addr_t       addr_tab [max_rows];
   tag_t        tag_tab  [max_rows];
   data_t       data_tab [max_rows];
   int          ref_tab  [max_rows];
   int          n_rows;
   int          limit;
   int          cycles;
   int          held;
   int          tb_errs;
   logic [31:0] rng;

   lsu_top i_dut (
      .clk(clk), .rst_n(rst_n), .flsh(flsh), .mem_rd(mem_rd), .mem_wrt(mem_wrt),
      .cmmt_str(cmmt_str), .addr_ls(addr_ls), .data_str(data_str), .indx_ls(indx_ls),
      .stll(stll), .vld_ld(vld_ld), .reg_wrt_ld(reg_wrt_ld), .indx_ld(indx_ld),
      .data_ld(data_ld), .str_iss(str_iss)
   );

   lsu_checker i_chk (
      .clk(clk), .rst_n(rst_n), .flsh(flsh), .mem_rd(mem_rd), .mem_wrt(mem_wrt),
      .cmmt_str(cmmt_str), .addr_ls(addr_ls), .data_str(data_str), .indx_ls(indx_ls),
      .stll(stll), .vld_ld(vld_ld), .indx_ld(indx_ld), .data_ld(data_ld),
      .str_iss(str_iss), .exp_vld(exp_vld), .exp_data(exp_data),
      .errors(errors), .checks(checks), .drained(drained)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Appends one row and returns its index
   function automatic int add_row(input int op, input addr_t addr, input tag_t tag,
                                  input int rref);
      op_tab[n_rows]   = op;
      addr_tab[n_rows] = addr;
      tag_tab[n_rows]  = tag;
      ref_tab[n_rows]  = rref;
      data_tab[n_rows] = '0;
      if (op == op_store) begin
         rng = xorshift(rng);
         data_tab[n_rows] = data_t'(rng);
      end
      n_rows++;
      return n_rows - 1;
   endfunction

   task automatic add_idles(input int n);
      repeat (n) void'(add_row(op_idle, '0, '0, no_ref));
   endtask

   task automatic build_table();
      int r20;
      int r30;
      int r40;
      int sq_rows [9];
      void'(add_row(op_load, 16'h0010, 6'd1, zero_ref));
      // Forwarding, the younger store wins
      r20 = add_row(op_store, 16'h0020, '0, no_ref);
      void'(add_row(op_load, 16'h0020, 6'd2, r20));
      r20 = add_row(op_store, 16'h0020, '0, no_ref);
      void'(add_row(op_load, 16'h0020, 6'd3, r20));
      // In-order write back of committed stores
      void'(add_row(op_commit, '0, '0, no_ref));
      void'(add_row(op_commit, '0, '0, no_ref));
      r30 = add_row(op_store, 16'h0030, '0, no_ref);
      void'(add_row(op_commit, '0, '0, no_ref));
      add_idles(8);
      void'(add_row(op_load, 16'h0030, 6'd4, r30));
      void'(add_row(op_load, 16'h0020, 6'd5, r20));
      // Flush drops uncommitted stores and a granted read
      r40 = add_row(op_store, 16'h0040, '0, no_ref);
      void'(add_row(op_commit, '0, '0, no_ref));
      void'(add_row(op_store, 16'h0040, '0, no_ref));
      void'(add_row(op_store, 16'h0050, '0, no_ref));
      void'(add_row(op_load, 16'h0060, 6'd6, no_ref));
      add_idles(1);
      void'(add_row(op_flush, '0, '0, no_ref));
      add_idles(8);
      void'(add_row(op_load, 16'h0040, 6'd7, r40));
      void'(add_row(op_load, 16'h0050, 6'd8, zero_ref));
      ////////////////////////////////////////////////////////////////////
      // Store queue full, then load queue full
      ////////////////////////////////////////////////////////////////////
      for (int k = 0; k < 7; k++) begin
         sq_rows[k] = add_row(op_store, addr_t'(16'h0080 + 2 * k), '0, no_ref);
      end
      void'(add_row(op_commit, '0, '0, no_ref));
      void'(add_row(op_commit, '0, '0, no_ref));
      sq_rows[7] = add_row(op_store, 16'h008e, '0, no_ref);
      sq_rows[8] = add_row(op_store, 16'h0090, '0, no_ref);
      for (int k = 0; k < 7; k++) begin
         void'(add_row(op_commit, '0, '0, no_ref));
      end
      add_idles(10);
      void'(add_row(op_load, 16'h0080, 6'd9, sq_rows[0]));
      void'(add_row(op_load, 16'h0090, 6'd10, sq_rows[8]));
      void'(add_row(op_load, 16'h0088, 6'd11, sq_rows[4]));
      for (int k = 0; k < 12; k++) begin
         void'(add_row(op_load, addr_t'(16'h00c0 + 2 * k), tag_t'(20 + k), zero_ref));
      end
      add_idles(1);
   endtask

   task automatic apply_row(input int i);
      flsh     = (op_tab[i] == op_flush);
      mem_rd   = (op_tab[i] == op_load);
      mem_wrt  = (op_tab[i] == op_store);
      cmmt_str = (op_tab[i] == op_commit);
      addr_ls  = addr_tab[i];
      data_str = data_tab[i];
      indx_ls  = tag_tab[i];
      exp_vld  = (op_tab[i] == op_load) && (ref_tab[i] != no_ref);
      if (ref_tab[i] >= 0) begin
         exp_data = data_tab[ref_tab[i]];
      end else begin
         exp_data = '0;
      end
   endtask

   // Run limit from the table length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("checks %0d, errors %0d", checks, errors + tb_errs + i_dut.i_props.fail_cnt);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      flsh     = 1'b0;
      mem_rd   = 1'b0;
      mem_wrt  = 1'b0;
      cmmt_str = 1'b0;
      addr_ls  = '0;
      data_str = '0;
      indx_ls  = '0;
      exp_vld  = 1'b0;
      exp_data = '0;
      n_rows   = 0;
      cycles   = 0;
      held     = 0;
      tb_errs  = 0;
      rng      = 32'd1256;
      limit    = 1000000;
      build_table();
      limit = 8 * n_rows + 200;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         apply_row(i);
         // Loads and stores wait out a stall
         while ((mem_rd || mem_wrt) && stll) begin
            held++;
            @(negedge clk);
         end
         @(negedge clk);
      end
      while (!drained) begin
         @(negedge clk);
      end
      repeat (10) @(negedge clk);
      if (held == 0) begin
         tb_errs++;
         $display("stll was never raised by a full queue");
      end
      $display("checks %0d, errors %0d", checks, errors + tb_errs + i_dut.i_props.fail_cnt);
      if ((errors + tb_errs + i_dut.i_props.fail_cnt) == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
